//--- source/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    // ==================================================
    // Major opcodes and CSR addresses
    // ==================================================
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [11:0] addr_mstatus = 12'h300;
    localparam logic [11:0] addr_mtvec   = 12'h305;
    localparam logic [11:0] addr_mepc    = 12'h341;
    localparam logic [11:0] addr_mcause  = 12'h342;

    typedef enum logic [3:0] {
        add, sub, sll, srl, sra, xor_op, or_op, and_op, slt, sltu, eq, pass_b
    } alu_op_t;

    typedef enum logic [1:0] {a_rs1, a_pc, a_zero} src_a_t;
    typedef enum logic [1:0] {b_rs2, b_imm, b_csr, b_zero} src_b_t;
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4, wb_csr} wb_sel_t;
    typedef enum logic [1:0] {csr_mstatus, csr_mtvec, csr_mepc, csr_mcause} csr_sel_t;

    // ==================================================
    // Instruction formats, one view per encoding
    // ==================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        alu_op_t  alu_op;
        src_a_t   src_a;
        src_b_t   src_b;
        wb_sel_t  wb_sel;
        logic     reg_wen;
        logic     mem_wen;
        logic     mem_ren;
        logic     branch;
        logic     branch_invert;  // Flips eq/slt/sltu for bne, bge and bgeu
        logic     jump;
        logic     jump_reg;
        logic     csr_wen;
        csr_sel_t csr_sel;
        logic     ecall;
        logic     mret;
    } ctrl_t;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  rv_pkg::inst_u              inst,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic [4:0]                 rd,
    output logic [rv_pkg::xlen-1:0]    imm,
    output rv_pkg::ctrl_t              ctrl
);

    // Shared by register and immediate ALU forms
    function automatic rv_pkg::alu_op_t alu_from_funct(input logic [2:0] funct3,
                                                       input logic alt);
        case (funct3)
            3'b000:  return alt ? rv_pkg::sub : rv_pkg::add;
            3'b001:  return rv_pkg::sll;
            3'b010:  return rv_pkg::slt;
            3'b011:  return rv_pkg::sltu;
            3'b100:  return rv_pkg::xor_op;
            3'b101:  return alt ? rv_pkg::sra : rv_pkg::srl;
            3'b110:  return rv_pkg::or_op;
            default: return rv_pkg::and_op;
        endcase
    endfunction

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;
    assign rd  = inst.r_fmt.rd;

    always_comb begin
        ctrl = '0;  // Defaults to a harmless add with no writes
        imm  = '0;
        case (inst.r_fmt.opcode)
            rv_pkg::op_lui: begin
                imm          = {inst.u_fmt.imm20, 12'b0};
                ctrl.alu_op  = rv_pkg::pass_b;
                ctrl.src_a   = rv_pkg::a_zero;
                ctrl.src_b   = rv_pkg::b_imm;
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_auipc: begin
                imm          = {inst.u_fmt.imm20, 12'b0};
                ctrl.src_a   = rv_pkg::a_pc;
                ctrl.src_b   = rv_pkg::b_imm;
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_jal: begin
                imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
                ctrl.jump    = 1'b1;
                ctrl.wb_sel  = rv_pkg::wb_pc4;
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_jalr: begin
                imm           = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
                ctrl.src_b    = rv_pkg::b_imm;
                ctrl.jump_reg = 1'b1;
                ctrl.wb_sel   = rv_pkg::wb_pc4;
                ctrl.reg_wen  = 1'b1;
            end
            rv_pkg::op_branch: begin
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
                ctrl.branch        = 1'b1;
                ctrl.branch_invert = inst.b_fmt.funct3[0];
                case (inst.b_fmt.funct3[2:1])
                    2'b00:   ctrl.alu_op = rv_pkg::eq;
                    2'b10:   ctrl.alu_op = rv_pkg::slt;
                    default: ctrl.alu_op = rv_pkg::sltu;
                endcase
            end
            rv_pkg::op_load: begin
                imm          = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
                ctrl.src_b   = rv_pkg::b_imm;
                ctrl.mem_ren = 1'b1;
                ctrl.wb_sel  = rv_pkg::wb_load;
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_store: begin
                imm          = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
                ctrl.src_b   = rv_pkg::b_imm;
                ctrl.mem_wen = 1'b1;
            end
            rv_pkg::op_imm: begin
                if (inst.i_fmt.funct3[1:0] == 2'b01) begin
                    imm = {27'b0, inst.i_fmt.imm12[4:0]};  // Shift amount
                end else begin
                    imm = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
                end
                ctrl.alu_op  = alu_from_funct(inst.i_fmt.funct3,
                                              inst.r_fmt.funct7[5] && inst.i_fmt.funct3 == 3'b101);
                ctrl.src_b   = rv_pkg::b_imm;
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_reg: begin
                ctrl.alu_op  = alu_from_funct(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
                ctrl.reg_wen = 1'b1;
            end
            rv_pkg::op_system: begin
                if (inst == 32'h0000_0073) begin
                    ctrl.ecall = 1'b1;
                end else if (inst == 32'h3020_0073) begin
                    ctrl.mret = 1'b1;
                end else if (inst.i_fmt.funct3 == 3'b001 || inst.i_fmt.funct3 == 3'b010) begin
                    // CSRRW passes rs1 through, CSRRS ors it into the old value
                    ctrl.alu_op  = inst.i_fmt.funct3[1] ? rv_pkg::or_op : rv_pkg::add;
                    ctrl.src_b   = inst.i_fmt.funct3[1] ? rv_pkg::b_csr : rv_pkg::b_zero;
                    ctrl.csr_wen = 1'b1;
                    ctrl.wb_sel  = rv_pkg::wb_csr;
                    ctrl.reg_wen = 1'b1;
                end
                case (inst.i_fmt.imm12)
                    rv_pkg::addr_mtvec:  ctrl.csr_sel = rv_pkg::csr_mtvec;
                    rv_pkg::addr_mepc:   ctrl.csr_sel = rv_pkg::csr_mepc;
                    rv_pkg::addr_mcause: ctrl.csr_sel = rv_pkg::csr_mcause;
                    default:             ctrl.csr_sel = rv_pkg::csr_mstatus;
                endcase
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- source/reg_csr_file.sv
`timescale 1ns/100ps

module reg_csr_file (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic [4:0]                 rd,
    input  logic [rv_pkg::xlen-1:0]    rd_value,
    input  logic                       reg_wen,
    input  rv_pkg::csr_sel_t           csr_sel,
    input  logic                       csr_wen,
    input  logic [rv_pkg::xlen-1:0]    csr_wdata,
    input  logic                       ecall,
    input  logic [rv_pkg::xlen-1:0]    pc,
    output logic [rv_pkg::xlen-1:0]    rs1_value,
    output logic [rv_pkg::xlen-1:0]    rs2_value,
    output logic [rv_pkg::xlen-1:0]    csr_value,
    output logic [rv_pkg::xlen-1:0]    mtvec,
    output logic [rv_pkg::xlen-1:0]    mepc,
    output logic [rv_pkg::xlen-1:0]    a0
);

    logic [rv_pkg::xlen-1:0] regs  [1:31];
    logic [rv_pkg::xlen-1:0] csr_q [4];

    // ==================================================
    // General registers
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && rd != 5'd0) begin  // x0 stays zero
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign a0        = regs[10];

    // ==================================================
    // Machine CSRs
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else if (ecall) begin
            // Trap entry wins over any CSR write
            csr_q[rv_pkg::csr_mepc]   <= pc;
            csr_q[rv_pkg::csr_mcause] <= 32'd11;  // Environment call from M-mode
        end else if (csr_wen) begin
            csr_q[csr_sel] <= csr_wdata;
        end
    end

    assign csr_value = csr_q[csr_sel];
    assign mtvec     = csr_q[rv_pkg::csr_mtvec];
    assign mepc      = csr_q[rv_pkg::csr_mepc];

endmodule

//--- source/exec_alu.sv
`timescale 1ns/100ps

module exec_alu (
    input  rv_pkg::alu_op_t            alu_op,
    input  rv_pkg::src_a_t             src_a,
    input  rv_pkg::src_b_t             src_b,
    input  logic                       branch_invert,
    input  logic [rv_pkg::xlen-1:0]    rs1_value,
    input  logic [rv_pkg::xlen-1:0]    rs2_value,
    input  logic [rv_pkg::xlen-1:0]    csr_value,
    input  logic [rv_pkg::xlen-1:0]    imm,
    input  logic [rv_pkg::xlen-1:0]    pc,
    output logic [rv_pkg::xlen-1:0]    result,
    output logic                       take_branch
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;

    always_comb begin
        case (src_a)
            rv_pkg::a_rs1: op_a = rs1_value;
            rv_pkg::a_pc:  op_a = pc;
            default:       op_a = '0;
        endcase
        case (src_b)
            rv_pkg::b_rs2: op_b = rs2_value;
            rv_pkg::b_imm: op_b = imm;
            rv_pkg::b_csr: op_b = csr_value;
            default:       op_b = '0;
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_pkg::add:    result = op_a + op_b;
            rv_pkg::sub:    result = op_a - op_b;
            rv_pkg::sll:    result = op_a << op_b[4:0];
            rv_pkg::srl:    result = op_a >> op_b[4:0];
            rv_pkg::sra:    result = $signed(op_a) >>> op_b[4:0];
            rv_pkg::xor_op: result = op_a ^ op_b;
            rv_pkg::or_op:  result = op_a | op_b;
            rv_pkg::and_op: result = op_a & op_b;
            rv_pkg::slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::sltu:   result = {31'b0, op_a < op_b};
            rv_pkg::eq:     result = {31'b0, op_a == op_b};
            rv_pkg::pass_b: result = op_b;
            default:        result = '0;
        endcase
    end

    assign take_branch = result[0] ^ branch_invert;  // Only meaningful for branches

endmodule

//--- source/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int DEPTH = 256
) (
    input  logic                       clk,
    input  logic [rv_pkg::xlen-1:0]    addr,
    input  logic [rv_pkg::xlen-1:0]    wdata,
    input  logic                       wen,
    output logic [rv_pkg::xlen-1:0]    rdata
);

    localparam int addr_w = $clog2(DEPTH);

    logic [rv_pkg::xlen-1:0] mem [DEPTH];
    logic [addr_w-1:0]       idx;

    assign idx = addr[addr_w+1:2];  // Word address, byte offset dropped

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

//--- source/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
    parameter logic [31:0] RESET_PC  = 32'h0000_0000,
    parameter int          RAM_DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  rv_pkg::inst_u              inst,
    output logic [rv_pkg::xlen-1:0]    fetch_pc,
    output logic [rv_pkg::xlen-1:0]    pc,
    output logic [rv_pkg::xlen-1:0]    a0,
    output logic [rv_pkg::xlen-1:0]    mtvec,
    output logic [rv_pkg::xlen-1:0]    mepc
);

    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    logic [rv_pkg::xlen-1:0] imm;
    rv_pkg::ctrl_t           ctrl;
    logic [rv_pkg::xlen-1:0] rs1_value;
    logic [rv_pkg::xlen-1:0] rs2_value;
    logic [rv_pkg::xlen-1:0] csr_value;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    take_branch;
    logic [rv_pkg::xlen-1:0] ram_rdata;
    logic [rv_pkg::xlen-1:0] wb_value;
    logic [rv_pkg::xlen-1:0] pc_plus4;

    inst_decoder inst_decoder_inst0 (
        .inst       (inst      ),
        .rs1        (rs1       ),
        .rs2        (rs2       ),
        .rd         (rd        ),
        .imm        (imm       ),
        .ctrl       (ctrl      )
    );

    reg_csr_file reg_csr_file_inst0 (
        .clk        (clk          ),
        .arst_n     (arst_n       ),
        .rs1        (rs1          ),
        .rs2        (rs2          ),
        .rd         (rd           ),
        .rd_value   (wb_value     ),
        .reg_wen    (ctrl.reg_wen ),
        .csr_sel    (ctrl.csr_sel ),
        .csr_wen    (ctrl.csr_wen ),
        .csr_wdata  (alu_result   ),
        .ecall      (ctrl.ecall   ),
        .pc         (pc           ),
        .rs1_value  (rs1_value    ),
        .rs2_value  (rs2_value    ),
        .csr_value  (csr_value    ),
        .mtvec      (mtvec        ),
        .mepc       (mepc         ),
        .a0         (a0           )
    );

    exec_alu exec_alu_inst0 (
        .alu_op         (ctrl.alu_op        ),
        .src_a          (ctrl.src_a         ),
        .src_b          (ctrl.src_b         ),
        .branch_invert  (ctrl.branch_invert ),
        .rs1_value      (rs1_value          ),
        .rs2_value      (rs2_value          ),
        .csr_value      (csr_value          ),
        .imm            (imm                ),
        .pc             (pc                 ),
        .result         (alu_result         ),
        .take_branch    (take_branch        )
    );

    data_ram #(
        .DEPTH      (RAM_DEPTH )
    ) data_ram_inst0 (
        .clk        (clk           ),
        .addr       (alu_result    ),
        .wdata      (rs2_value     ),
        .wen        (ctrl.mem_wen  ),
        .rdata      (ram_rdata     )
    );

    // ==================================================
    // Write-back and next PC
    // ==================================================
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::wb_load: wb_value = ctrl.mem_ren ? ram_rdata : '0;
            rv_pkg::wb_pc4:  wb_value = pc_plus4;
            rv_pkg::wb_csr:  wb_value = csr_value;  // Old CSR value goes to rd
            default:         wb_value = alu_result;
        endcase
    end

    always_comb begin
        if (ctrl.ecall) begin
            fetch_pc = mtvec;
        end else if (ctrl.mret) begin
            fetch_pc = mepc;
        end else if (ctrl.jump_reg) begin
            fetch_pc = {alu_result[31:1], 1'b0};
        end else if (ctrl.jump || (ctrl.branch && take_branch)) begin
            fetch_pc = pc + imm;
        end else begin
            fetch_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= fetch_pc;
        end
    end

endmodule

//--- testbench/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

    localparam logic [31:0] reset_pc    = 32'h0000_0100;
    localparam logic [31:0] nop_word    = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] poison_word = 32'h5a50_0513;  // addi x10, x0, 0x5a5 on a skipped slot
    localparam logic [31:0] ecall_word  = 32'h0000_0073;
    localparam logic [31:0] mret_word   = 32'h3020_0073;

    localparam logic [1:0] sig_a0    = 2'd0;
    localparam logic [1:0] sig_mtvec = 2'd1;
    localparam logic [1:0] sig_mepc  = 2'd2;
    localparam logic [1:0] sig_next  = 2'd3;

    // One expected value of one DUT output, taken when pc sits on a given address
    typedef struct packed {
        logic [1:0]  sig;
        logic [31:0] pc;
        logic [31:0] value;
    } check_t;

    logic           clk;
    logic           arst_n = 1'b0;
    rv_pkg::inst_u  inst   = nop_word;
    logic [31:0]    fetch_pc;
    logic [31:0]    pc;
    logic [31:0]    a0;
    logic [31:0]    mtvec;
    logic [31:0]    mepc;

    logic [31:0] rom [$];
    check_t      checks [$];
    bit          hit [$];
    logic [31:0] end_pc  = '0;
    logic [31:0] seen;
    int          errors  = 0;
    int          cycles  = 0;
    int          limit   = 0;
    bit          started = 1'b0;

    rv_core #(
        .RESET_PC   (reset_pc ),
        .RAM_DEPTH  (64       )
    ) dut (
        .clk        (clk      ),
        .arst_n     (arst_n   ),
        .inst       (inst     ),
        .fetch_pc   (fetch_pc ),
        .pc         (pc       ),
        .a0         (a0       ),
        .mtvec      (mtvec    ),
        .mepc       (mepc     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================
    // Instruction encoders and program helpers
    // ==================================================
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], rv_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], rv_pkg::op_branch};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd, input logic [6:0] op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), rv_pkg::op_jal};
    endfunction

    function automatic logic [31:0] here();
        return reset_pc + 32'(4 * rom.size());  // Address of the next word placed
    endfunction

    function automatic logic [31:0] rom_at(input logic [31:0] addr);
        int idx;
        idx = int'((addr - reset_pc) >> 2);
        if (addr < reset_pc || idx >= rom.size()) begin
            return nop_word;
        end
        return rom[idx];
    endfunction

    function automatic string sig_name(input logic [1:0] sig);
        case (sig)
            sig_a0:    return "a0";
            sig_mtvec: return "mtvec";
            sig_mepc:  return "mepc";
            default:   return "fetch_pc";
        endcase
    endfunction

    task automatic put(input logic [31:0] word);
        rom.push_back(word);
    endtask

    task automatic expect_at(input logic [1:0] sig, input logic [31:0] value);
        check_t c;
        c.sig   = sig;
        c.pc    = here();
        c.value = value;
        checks.push_back(c);
        hit.push_back(1'b0);
    endtask

    // A failing compare falls through, a passing one skips a poisoned slot
    task automatic branch_test(input int f3, input int nt_rs1, input int nt_rs2,
                               input int t_rs1, input int t_rs2);
        expect_at(sig_next, here() + 4);
        put(b_type(8, nt_rs2, nt_rs1, f3));
        expect_at(sig_next, here() + 8);
        put(b_type(8, t_rs2, t_rs1, f3));
        put(poison_word);
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks.size(), errors, cycles);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ==================================================
    // Program, with x1 = -7 and x2 = 3 as operands
    // ==================================================
    initial begin
        logic [31:0] t;
        logic [31:0] h;
        logic [31:0] e;
        logic [31:0] link;
        expect_at(sig_a0, 0);  // State right after reset
        expect_at(sig_mtvec, 0);
        expect_at(sig_mepc, 0);
        put(i_type(-7, 0, 0, 1, rv_pkg::op_imm));
        put(i_type(3, 0, 0, 2, rv_pkg::op_imm));
        put(r_type(0, 2, 1, 0, 10));                   // add
        expect_at(sig_a0, 32'hffff_fffc);
        put(r_type(32, 2, 1, 0, 10));                  // sub
        expect_at(sig_a0, 32'hffff_fff6);
        put(r_type(0, 2, 1, 4, 10));                   // xor
        expect_at(sig_a0, 32'hffff_fffa);
        put(r_type(0, 2, 1, 6, 10));                   // or
        expect_at(sig_a0, 32'hffff_fffb);
        put(r_type(0, 2, 1, 7, 10));                   // and
        expect_at(sig_a0, 32'h0000_0001);
        put(r_type(0, 2, 1, 1, 10));                   // sll
        expect_at(sig_a0, 32'hffff_ffc8);
        put(r_type(0, 2, 1, 5, 10));                   // srl
        expect_at(sig_a0, 32'h1fff_ffff);
        put(r_type(32, 2, 1, 5, 10));                  // sra
        expect_at(sig_a0, 32'hffff_ffff);
        put(r_type(0, 2, 1, 2, 10));                   // slt
        expect_at(sig_a0, 32'h0000_0001);
        put(r_type(0, 2, 1, 3, 10));                   // sltu
        expect_at(sig_a0, 32'h0000_0000);
        put(i_type('h401, 1, 5, 10, rv_pkg::op_imm));  // srai by one
        expect_at(sig_a0, 32'hffff_fffc);
        put(i_type(5, 2, 0, 0, rv_pkg::op_imm));       // Write to x0 must be lost
        put(r_type(0, 0, 2, 0, 10));
        expect_at(sig_a0, 3);
        put(u_type('habcde, 10, rv_pkg::op_lui));
        expect_at(sig_a0, 32'habcd_e000);
        t = here();
        put(u_type('h12345, 10, rv_pkg::op_auipc));
        expect_at(sig_a0, t + 32'h1234_5000);
        put(s_type(16, 1, 0));
        put(s_type(20, 2, 0));
        put(i_type(16, 0, 2, 10, rv_pkg::op_load));
        expect_at(sig_a0, 32'hffff_fff9);
        put(i_type(20, 0, 2, 10, rv_pkg::op_load));
        expect_at(sig_a0, 3);
        branch_test(0, 1, 2, 2, 2);                    // beq
        branch_test(1, 2, 2, 1, 2);                    // bne
        branch_test(4, 2, 1, 1, 2);                    // blt
        branch_test(5, 1, 2, 2, 1);                    // bge
        branch_test(6, 1, 2, 2, 1);                    // bltu
        branch_test(7, 2, 1, 1, 2);                    // bgeu
        link = here() + 4;
        expect_at(sig_next, here() + 8);
        put(j_type(8, 10));
        put(poison_word);
        expect_at(sig_a0, link);
        t = here() + 12;
        put(i_type(int'(t), 0, 0, 5, rv_pkg::op_imm));
        expect_at(sig_next, t);                        // Bit 0 of x5 + 1 is dropped
        link = here() + 4;
        put(i_type(1, 5, 0, 10, rv_pkg::op_jalr));
        put(poison_word);
        expect_at(sig_a0, link);

        h = here() + 32;  // Trap handler sits right after the final self-loop
        put(i_type(int'(h), 0, 0, 6, rv_pkg::op_imm));
        put(i_type('h305, 6, 1, 10, rv_pkg::op_system));  // csrrw x10, mtvec, x6
        expect_at(sig_a0, 0);
        expect_at(sig_mtvec, h);
        put(i_type('h300, 2, 2, 10, rv_pkg::op_system));  // csrrs x10, mstatus, x2
        expect_at(sig_a0, 0);
        put(i_type('h300, 0, 2, 10, rv_pkg::op_system));
        expect_at(sig_a0, 3);
        put(i_type('h305, 0, 2, 10, rv_pkg::op_system));
        e = here();
        expect_at(sig_a0, h);
        expect_at(sig_next, h);
        put(ecall_word);
        expect_at(sig_mepc, e + 4);
        put(i_type('h77, 0, 0, 10, rv_pkg::op_imm));
        end_pc = here();
        expect_at(sig_a0, 'h77);
        put(j_type(0, 0));
        expect_at(sig_mepc, e);                        // Handler entry
        put(i_type('h342, 0, 2, 10, rv_pkg::op_system));  // csrrs x10, mcause, x0
        expect_at(sig_a0, 11);
        put(i_type('h341, 0, 2, 7, rv_pkg::op_system));
        put(i_type(4, 7, 0, 7, rv_pkg::op_imm));
        put(i_type('h341, 7, 1, 0, rv_pkg::op_system));
        expect_at(sig_mepc, e + 4);
        expect_at(sig_next, e + 4);
        put(mret_word);
        limit = 8 + 5 * rom.size();
    end

    // ==================================================
    // Reset release and instruction fetch
    // ==================================================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 7) begin
            arst_n <= 1'b1;
            inst   <= rom_at(reset_pc);
        end else if (arst_n) begin
            inst <= rom_at(fetch_pc);  // Keeps inst in step with pc
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (!started) begin
                started = 1'b1;
                assert (pc == reset_pc) else begin
                    $display("Mismatch pc after reset: got %h, expected %h", pc, reset_pc);
                    errors++;
                end
            end
            for (int i = 0; i < checks.size(); i++) begin
                if (pc == checks[i].pc) begin
                    hit[i] = 1'b1;
                    case (checks[i].sig)
                        sig_a0:    seen = a0;
                        sig_mtvec: seen = mtvec;
                        sig_mepc:  seen = mepc;
                        default:   seen = fetch_pc;
                    endcase
                    assert (seen == checks[i].value) else begin
                        $display("Mismatch %s at pc %h: got %h, expected %h",
                                 sig_name(checks[i].sig), pc, seen, checks[i].value);
                        errors++;
                    end
                end
            end
        end
        if (arst_n && pc == end_pc) begin
            for (int i = 0; i < checks.size(); i++) begin
                if (!hit[i]) begin
                    $display("The check of %s at pc %h was never reached",
                             sig_name(checks[i].sig), checks[i].pc);
                    errors++;
                end
            end
            end_run();
        end else if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the program never reached its final self-loop",
                     cycles);
            errors++;
            end_run();
        end
    end

endmodule

//--- rv_core.f
source/rv_pkg.sv
source/inst_decoder.sv
source/reg_csr_file.sv
source/exec_alu.sv
source/data_ram.sv
source/rv_core.sv
testbench/rv_core_tb.sv

//--- Makefile
SIM = obj_dir/rv_core_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert --timescale 1ns/100ps --top-module rv_core_tb \
		-f rv_core.f -o rv_core_sim
	@out=$$(./$(SIM)); echo "$$out"; \
		echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
